// ==== src/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen_w     = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen_w-1:0] reset_pc = 32'h8000_0000;

  // opcodes of the supported subset
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  // access size codes, shared by loads and stores
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  // data bus sequencer states
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_request = 2'd1;
  localparam logic [1:0] st_release = 2'd2;
  localparam logic [1:0] st_finish  = 2'd3;

  // one instruction word, viewed in each encoding format
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } s;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic        imm_20;
      logic [9:0]  imm_10_1;
      logic        imm_11;
      logic [7:0]  imm_19_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } j;
  } inst_t;

endpackage

// ==== src/rv_ifs.sv ====
`timescale 1ns/100ps

// decoded instruction fields and operation flags
interface dec_if import rv_pkg::*; ();
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen_w-1:0]     imm;
  logic [2:0]            funct3;
  logic is_addi, is_lui, is_auipc, is_jal, is_jalr;
  logic is_load, is_store, is_halt;

  modport decoder (output rs1, rs2, rd, imm, funct3, is_addi, is_lui, is_auipc,
                   is_jal, is_jalr, is_load, is_store, is_halt);
  modport regfile (input rs1, rs2);
  modport execute (input rd, imm, funct3, is_addi, is_lui, is_auipc, is_jal,
                   is_jalr, is_load, is_store, is_halt);
endinterface

// start/done handshake between execute and the load/store unit
interface lsu_if import rv_pkg::*; ();
  logic              start;
  logic              done;
  logic [xlen_w-1:0] addr;
  logic [xlen_w-1:0] wdata;
  logic [xlen_w-1:0] rdata;
  logic [2:0]        funct3;
  logic              is_store;

  modport execute (output start, addr, wdata, funct3, is_store,
                   input done, rdata);
  modport memory (input start, addr, wdata, funct3, is_store,
                  output done, rdata);
endinterface

// ==== src/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
  input inst_t   inst,
  dec_if.decoder dec
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [xlen_w-1:0] imm_i;
  logic [xlen_w-1:0] imm_s;
  logic [xlen_w-1:0] imm_u;
  logic [xlen_w-1:0] imm_j;

  assign opcode = inst.i.opcode; // same position in every format
  assign funct3 = inst.i.funct3;

  assign dec.rs1    = inst.i.rs1;
  assign dec.rs2    = inst.s.rs2;
  assign dec.rd     = inst.i.rd;
  assign dec.funct3 = funct3;

  // immediates, sign taken from bit 31
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_u = {inst.u.imm, 12'h000}; // already in the upper bits
  assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  always_comb begin
    case (opcode)
      op_store:         dec.imm = imm_s;
      op_lui, op_auipc: dec.imm = imm_u;
      op_jal:           dec.imm = imm_j;
      default:          dec.imm = imm_i; // addi, jalr, loads
    endcase
  end

  // one-hot flags, anything else stays a no-op
  assign dec.is_addi  = (opcode == op_imm) && (funct3 == 3'b000);
  assign dec.is_lui   = (opcode == op_lui);
  assign dec.is_auipc = (opcode == op_auipc);
  assign dec.is_jal   = (opcode == op_jal);
  assign dec.is_jalr  = (opcode == op_jalr);
  assign dec.is_load  = (opcode == op_load);
  assign dec.is_store = (opcode == op_store);

  // ebreak only, ecall falls through as a no-op
  assign dec.is_halt  = (opcode == op_system) && (funct3 == 3'b000) &&
                        (inst.i.imm == 12'h001);

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  dec_if.regfile                dec,
  input  logic                  rd_we,
  input  logic [reg_addr_w-1:0] rd_addr,
  input  logic [xlen_w-1:0]     rd_data,
  output logic [xlen_w-1:0]     rs1_data,
  output logic [xlen_w-1:0]     rs2_data
);

  logic [xlen_w-1:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (rd_we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// ==== src/rv_exec.sv ====
`timescale 1ns/100ps

module rv_exec import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  dec_if.execute                dec,
  input  logic [xlen_w-1:0]     rs1_data,
  input  logic [xlen_w-1:0]     rs2_data,
  lsu_if.execute                lsu,
  output logic                  rd_we,
  output logic [reg_addr_w-1:0] rd_addr,
  output logic [xlen_w-1:0]     rd_data,
  output logic [xlen_w-1:0]     pc,
  output logic                  halt
);

  logic              mem_op;
  logic              done_q;  // keeps start low for one cycle after done
  logic              step;    // instruction retires at this edge
  logic [xlen_w-1:0] op_a;
  logic [xlen_w-1:0] sum;
  logic [xlen_w-1:0] pc_plus4;
  logic [xlen_w-1:0] pc_next;

  assign mem_op   = dec.is_load | dec.is_store;
  assign pc_plus4 = pc + 32'd4;

  // single adder for results, addresses and jump targets
  assign op_a = (dec.is_auipc | dec.is_jal) ? pc : rs1_data;
  assign sum  = op_a + dec.imm;

  assign step = !halt && !dec.is_halt && (!mem_op || lsu.done);

  always_comb begin
    if (dec.is_jal)       pc_next = sum;
    else if (dec.is_jalr) pc_next = {sum[xlen_w-1:1], 1'b0};
    else                  pc_next = pc_plus4;
  end

  // write-back
  assign rd_addr = dec.rd;
  assign rd_we   = step && (dec.is_addi | dec.is_lui | dec.is_auipc |
                            dec.is_jal | dec.is_jalr | dec.is_load);

  always_comb begin
    if (dec.is_lui)                    rd_data = dec.imm;
    else if (dec.is_jal | dec.is_jalr) rd_data = pc_plus4; // link
    else if (dec.is_load)              rd_data = lsu.rdata;
    else                               rd_data = sum;
  end

  // load/store request, fields stable while pc holds
  assign lsu.start    = mem_op && !halt && !done_q;
  assign lsu.addr     = sum;
  assign lsu.wdata    = rs2_data;
  assign lsu.funct3   = dec.funct3;
  assign lsu.is_store = dec.is_store;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= reset_pc;
      halt   <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= lsu.done;
      if (step) pc <= pc_next;
      if (!halt && dec.is_halt) halt <= 1'b1; // sticky until reset
    end
  end

endmodule

// ==== src/rv_lsu.sv ====
`timescale 1ns/100ps

module rv_lsu import rv_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  lsu_if.memory             lsu,
  output logic              dmem_req,
  output logic              dmem_we,
  output logic [xlen_w-1:0] dmem_addr,
  output logic [xlen_w-1:0] dmem_wdata,
  output logic [3:0]        dmem_wmask,
  input  logic [xlen_w-1:0] dmem_rdata,
  input  logic              dmem_ack
);

  logic [1:0]        state;
  logic [xlen_w-1:0] rdata_q; // word captured while ack is high
  logic [1:0]        ofs;
  logic [3:0]        mask;
  logic [7:0]        lane_b;
  logic [15:0]       lane_h;

  assign ofs = lsu.addr[1:0];

  // four-phase sequencer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:    if (lsu.start) state <= st_request;
        st_request: if (dmem_ack) state <= st_release;
        st_release: if (!dmem_ack) state <= st_finish;
        default:    state <= st_idle; // finish, done for one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == st_request) && dmem_ack) rdata_q <= dmem_rdata;
  end

  assign dmem_req   = (state == st_request);
  assign dmem_we    = lsu.is_store;
  assign dmem_addr  = lsu.addr;
  assign dmem_wdata = lsu.wdata << {ofs, 3'b000}; // into the addressed lane
  assign dmem_wmask = lsu.is_store ? mask : 4'b0000;
  assign lsu.done   = (state == st_finish);

  // byte lanes, misaligned halves and words write nothing
  always_comb begin
    case (lsu.funct3)
      f3_b:    mask = 4'b0001 << ofs;
      f3_h:    mask = ofs[0] ? 4'b0000 : (4'b0011 << ofs);
      f3_w:    mask = (ofs == 2'b00) ? 4'b1111 : 4'b0000;
      default: mask = 4'b0000;
    endcase
  end

  assign lane_b = rdata_q[{ofs, 3'b000} +: 8];
  assign lane_h = ofs[1] ? rdata_q[31:16] : rdata_q[15:0];

  // lane extraction and extension
  always_comb begin
    case (lsu.funct3)
      f3_b:    lsu.rdata = {{24{lane_b[7]}}, lane_b};
      f3_bu:   lsu.rdata = {24'h000000, lane_b};
      f3_h:    lsu.rdata = ofs[0] ? '0 : {{16{lane_h[15]}}, lane_h};
      f3_hu:   lsu.rdata = ofs[0] ? '0 : {16'h0000, lane_h};
      f3_w:    lsu.rdata = (ofs == 2'b00) ? rdata_q : '0;
      default: lsu.rdata = '0;
    endcase
  end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  inst_t             inst,
  output logic [xlen_w-1:0] pc,
  output logic              dmem_req,
  output logic              dmem_we,
  output logic [xlen_w-1:0] dmem_addr,
  output logic [xlen_w-1:0] dmem_wdata,
  output logic [3:0]        dmem_wmask,
  input  logic [xlen_w-1:0] dmem_rdata,
  input  logic              dmem_ack,
  output logic              halt
);

  logic                  rd_we;
  logic [reg_addr_w-1:0] rd_addr;
  logic [xlen_w-1:0]     rd_data;
  logic [xlen_w-1:0]     rs1_data;
  logic [xlen_w-1:0]     rs2_data;

  dec_if u_dec_if ();
  lsu_if u_lsu_if ();

  rv_decode u_decode (.inst(inst), .dec(u_dec_if.decoder));

  rv_regfile u_regfile (
    .clk(clk), .arst_n(arst_n), .dec(u_dec_if.regfile),
    .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_exec u_exec (
    .clk(clk), .arst_n(arst_n), .dec(u_dec_if.execute),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .lsu(u_lsu_if.execute),
    .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data), .pc(pc), .halt(halt)
  );

  rv_lsu u_lsu (
    .clk(clk), .arst_n(arst_n), .lsu(u_lsu_if.memory),
    .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
    .dmem_rdata(dmem_rdata), .dmem_ack(dmem_ack)
  );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // reset held over four rising edges, released just after the last one
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
  end

endmodule

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core import rv_pkg::*; ();

  typedef enum logic [1:0] {k_op, k_load, k_store, k_halt} kind_t;

  typedef struct {
    string       name;
    logic [31:0] pc;
    inst_t       inst;
    kind_t       kind;
    logic [31:0] addr;
    logic [31:0] rdata; // word returned for a load
    logic [31:0] wdata; // expected store data
    logic [3:0]  wmask;
  } entry_t;

  logic        clk;
  logic        arst_n;
  inst_t       inst;
  logic [31:0] pc;
  logic        dmem_req;
  logic        dmem_we;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wmask;
  logic [31:0] dmem_rdata;
  logic        dmem_ack;
  logic        halt;

  entry_t      prog[$];
  logic [31:0] bld_pc;
  logic [31:0] data_base;
  logic [31:0] load_word;
  int          cur;
  int          seed;
  int          accesses;   // handshakes completed by the responder
  int          mem_seen;
  int          cycles;
  int          cycle_limit;

  clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

  rv_core u_rv_core (
    .clk(clk), .arst_n(arst_n), .inst(inst), .pc(pc),
    .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
    .dmem_rdata(dmem_rdata), .dmem_ack(dmem_ack), .halt(halt)
  );

  task automatic fail_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
      else fail_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
  endtask

  // instruction words assembled through the union views
  function automatic inst_t enc_i(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                  logic [4:0] rs1, logic [11:0] imm);
    inst_t w;
    w.i = '{imm, rs1, f3, rd, op};
    return w;
  endfunction

  function automatic inst_t enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                  logic [11:0] imm);
    inst_t w;
    w.s = '{imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    return w;
  endfunction

  function automatic inst_t enc_u(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    inst_t w;
    w.u = '{imm, rd, op};
    return w;
  endfunction

  function automatic inst_t enc_j(logic [4:0] rd, logic [20:0] imm);
    inst_t w;
    w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    return w;
  endfunction

  task automatic add_entry(string name, inst_t word, kind_t kind = k_op,
                           logic [31:0] addr = '0, logic [31:0] rdata = '0,
                           logic [31:0] wdata = '0, logic [3:0] wmask = '0);
    entry_t e;
    e.name  = name;
    e.pc    = bld_pc;
    e.inst  = word;
    e.kind  = kind;
    e.addr  = addr;
    e.rdata = rdata;
    e.wdata = wdata;
    e.wmask = wmask;
    prog.push_back(e);
    bld_pc = bld_pc + 32'd4;
  endtask

  // load into x7 from data_base+0x20+ofs, then sw x7 to data_base+0x40
  task automatic load_and_store(string name, logic [2:0] f3, int ofs, logic [31:0] result);
    logic [11:0] imm;
    imm = 12'h020 + 12'(ofs);
    add_entry($sformatf("%s %0d", name, ofs), enc_i(op_load, 5'd7, f3, 5'd10, imm),
              k_load, data_base + 32'h20 + 32'(ofs), load_word);
    add_entry($sformatf("%s %0d store", name, ofs), enc_s(f3_w, 5'd10, 5'd7, 12'h040),
              k_store, data_base + 32'h40, '0, result, 4'hf);
  endtask

  task automatic build_program();
    logic [31:0] x1;
    logic [31:0] x2;
    logic [31:0] x3;
    logic [31:0] x4;
    logic [31:0] x5;
    logic [31:0] x6;
    logic [31:0] tgt;
    logic [7:0]  b;
    logic [15:0] h;
    bld_pc    = reset_pc;
    data_base = 32'h1000_0000;
    load_word = 32'h7f80_c634; // bytes 34 c6 80 7f, mixed signs
    x1 = 32'h0000_0123;
    x2 = 32'h1234_5000 + 32'hffff_ffff; // lui then addi -1
    add_entry("addi x1", enc_i(op_imm, 5'd1, 3'd0, 5'd0, 12'h123));
    add_entry("lui x2", enc_u(op_lui, 5'd2, 20'h12345));
    add_entry("addi x2", enc_i(op_imm, 5'd2, 3'd0, 5'd2, 12'hfff));
    x3 = bld_pc + 32'h0001_0000;
    add_entry("auipc x3", enc_u(op_auipc, 5'd3, 20'h00010));
    add_entry("lui x10", enc_u(op_lui, 5'd10, 20'h10000));
    add_entry("sw x1", enc_s(f3_w, 5'd10, 5'd1, 12'h000), k_store, data_base, '0, x1, 4'hf);
    add_entry("sw x2", enc_s(f3_w, 5'd10, 5'd2, 12'h004), k_store, data_base + 4, '0, x2, 4'hf);
    add_entry("sw x3", enc_s(f3_w, 5'd10, 5'd3, 12'h008), k_store, data_base + 8, '0, x3, 4'hf);
    x4  = bld_pc + 32'd4;
    tgt = bld_pc + 32'd16;
    add_entry("jal x4", enc_j(5'd4, 21'd16));
    bld_pc = tgt;
    x5 = bld_pc;
    add_entry("auipc x5", enc_u(op_auipc, 5'd5, 20'h00000));
    x6  = bld_pc + 32'd4;
    tgt = (x5 + 32'd21) & ~32'd1; // odd offset, bit 0 dropped
    add_entry("jalr x6", enc_i(op_jalr, 5'd6, 3'd0, 5'd5, 12'd21));
    bld_pc = tgt;
    add_entry("sw x4", enc_s(f3_w, 5'd10, 5'd4, 12'h00c), k_store, data_base + 12, '0, x4, 4'hf);
    add_entry("sw x6", enc_s(f3_w, 5'd10, 5'd6, 12'h010), k_store, data_base + 16, '0, x6, 4'hf);
    for (int ofs = 0; ofs < 4; ofs++) begin
      b = load_word[8*ofs +: 8];
      load_and_store("lb", f3_b, ofs, {{24{b[7]}}, b});
      load_and_store("lbu", f3_bu, ofs, {24'h000000, b});
    end
    for (int ofs = 0; ofs < 4; ofs += 2) begin
      h = load_word[8*ofs +: 16];
      load_and_store("lh", f3_h, ofs, {{16{h[15]}}, h});
      load_and_store("lhu", f3_hu, ofs, {16'h0000, h});
    end
    load_and_store("lw", f3_w, 0, load_word);
    // byte and half lanes from x2
    for (int ofs = 0; ofs < 4; ofs++)
      add_entry($sformatf("sb %0d", ofs), enc_s(f3_b, 5'd10, 5'd2, 12'h060 + 12'(ofs)),
                k_store, data_base + 32'h60 + 32'(ofs), '0, x2 << (8 * ofs), 4'b0001 << ofs);
    for (int ofs = 0; ofs < 4; ofs += 2)
      add_entry($sformatf("sh %0d", ofs), enc_s(f3_h, 5'd10, 5'd2, 12'h070 + 12'(ofs)),
                k_store, data_base + 32'h70 + 32'(ofs), '0, x2 << (8 * ofs), 4'b0011 << ofs);
    add_entry("ebreak", enc_i(op_system, 5'd0, 3'd0, 5'd0, 12'h001), k_halt);
  endtask

  // one four-phase transfer, answered after 1 to 3 cycles
  task automatic serve_request();
    entry_t e;
    int     delay;
    e = prog[cur];
    assert (e.kind == k_load || e.kind == k_store)
      else fail_run($sformatf("data request during %s, which is no load or store", e.name));
    check_value({e.name, " addr"}, e.addr, dmem_addr);
    check_value({e.name, " we"}, 32'(e.kind == k_store), 32'(dmem_we));
    delay = 1 + int'($unsigned($random(seed)) % 3);
    repeat (delay) begin
      @(posedge clk);
      #2;
      assert (dmem_req === 1'b1) else fail_run("dmem_req dropped before ack");
      check_value({e.name, " pc in handshake"}, e.pc, pc);
    end
    if (e.kind == k_store) begin
      check_value({e.name, " wmask"}, {28'h0, e.wmask}, {28'h0, dmem_wmask});
      check_value({e.name, " wdata"}, e.wdata, dmem_wdata);
    end
    dmem_rdata = e.rdata;
    dmem_ack   = 1'b1;
    do begin
      @(posedge clk);
      #2;
      check_value({e.name, " pc in handshake"}, e.pc, pc);
    end while (dmem_req);
    dmem_ack   = 1'b0;
    dmem_rdata = '0;
    accesses++;
  endtask

  initial begin
    dmem_ack   = 1'b0;
    dmem_rdata = '0;
    forever begin
      @(posedge clk);
      #2;
      if (dmem_req) serve_request();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit)
      fail_run($sformatf("timeout, program not finished after %0d cycles", cycles));
  end

  initial begin
    seed = 55;
    inst = enc_i(op_imm, 5'd0, 3'd0, 5'd0, 12'h000); // nop while in reset
    build_program();
    cycle_limit = 4 + prog.size() * 12;
    @(posedge arst_n);
    check_value("reset pc", reset_pc, pc);
    assert (dmem_req === 1'b0 && halt === 1'b0)
      else fail_run("dmem_req or halt is high right after reset");
    for (int i = 0; i < prog.size(); i++) begin
      check_value({prog[i].name, " fetch pc"}, prog[i].pc, pc);
      inst = prog[i].inst;
      cur  = i;
      if (prog[i].kind == k_halt) begin
        @(posedge clk);
        #2;
        assert (halt === 1'b1) else fail_run("halt did not rise after ebreak");
        // a store while halted must neither move pc nor reach the bus
        inst = enc_s(f3_w, 5'd10, 5'd1, 12'h000);
        repeat (5) begin
          @(posedge clk);
          #2;
          check_value("ebreak pc hold", prog[i].pc, pc);
          assert (dmem_req === 1'b0) else fail_run("data request while halted");
        end
      end else begin
        do begin
          @(posedge clk);
          #2;
        end while (pc === prog[i].pc);
        if (prog[i].kind != k_op) begin
          mem_seen++;
          assert (accesses == mem_seen)
            else fail_run($sformatf("pc left %s before its handshake ended", prog[i].name));
        end
      end
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== list.f ====
src/rv_pkg.sv
src/rv_ifs.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_exec.sv
src/rv_lsu.sv
src/rv_core.sv
bench/clock_gen.sv
bench/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_rv_core
FILE_LIST ?= list.f
LOG       ?= sim.log
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "=== PASS ===" $(LOG) && echo "result: passed" || (echo "result: failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
